//--- Bender.yml
package:
  name: sd_card_switch

sources:
  # package and interface first
  - common/sd_pkg.sv
  - common/sd_port_if.sv
  # request filter
  - hdl/sdreq_sync.sv
  # arbiter block, top level last
  - sd_arbiter/sd_grant_ctrl.sv
  - sd_arbiter/sd_spi_mux.sv
  - sd_arbiter/sd_card_switch.sv

  # testbench and bound checks
  - target: test
    files:
      - verification/sd_card_switch_chk.sv
      - verification/tb_sd_card_switch.sv

//--- all.f
common/sd_pkg.sv
common/sd_port_if.sv
hdl/sdreq_sync.sv
sd_arbiter/sd_grant_ctrl.sv
sd_arbiter/sd_spi_mux.sv
sd_arbiter/sd_card_switch.sv
verification/sd_card_switch_chk.sv
verification/tb_sd_card_switch.sv

//--- common/sd_pkg.sv
/*
 * Shared types and constants for the SD card access switch.
 * Six disk controllers share one card. Bit order is fixed (RK is bit 0, MY is bit 5),
 * and the lowest index has the highest priority.
 */
package sd_pkg;

   //********************
   // controller layout
   //********************
   typedef logic [5:0] sd_vec_t;           // one bit per controller

   localparam int idx_rk = 0;              // RK11, highest priority
   localparam int idx_dw = 1;              // DW hard disk
   localparam int idx_dm = 2;              // RK611
   localparam int idx_db = 3;              // RH70
   localparam int idx_dx = 4;              // RX01
   localparam int idx_my = 5;              // MY floppy, lowest priority

   //********************
   // grant word
   //********************
   // field order is msb first, so rk lands on bit 0
   typedef struct packed {
      logic my;                            // bit 5
      logic dx;                            // bit 4
      logic db;                            // bit 3
      logic dm;                            // bit 2
      logic dw;                            // bit 1
      logic rk;                            // bit 0
   } sd_grant_s;

   // grant seen as a column select or as named owners
   typedef union packed {
      sd_vec_t   vec;                      // mux column view
      sd_grant_s dev;                      // per-controller view
   } sd_grant_u;

   //********************
   // card line defaults
   //********************
   localparam logic idle_cs   = 1'b1;      // card deselected
   localparam logic idle_mosi = 1'b1;      // spi line idles high
   localparam logic idle_sclk = 1'b0;      // clock parked low

   localparam int sync_stages_dflt = 2;    // request filter depth

endpackage

//--- common/sd_port_if.sv
/*
 * Internal bundle between the request filter, the grant register and the card mux.
 * The controller SPI lines are driven from the top level ports.
 */
interface sd_port_if
   import sd_pkg::*;
();

   //********************
   // request / grant
   //********************
   sd_vec_t   req;                         // filtered requests
   sd_grant_u grant;                       // current card owner, at most one bit

   //********************
   // controller spi lines
   //********************
   sd_vec_t   cs;                          // chip selects, one per controller
   sd_vec_t   mosi;                        // data towards the card
   sd_vec_t   sclk;                        // spi clocks

   // filter side
   modport sync_mp (
      output req
   );

   // grant register side
   modport arb_mp (
      input  req,
      output grant
   );

   // card mux side
   modport mux_mp (
      input  grant,
      input  cs,
      input  mosi,
      input  sclk
   );

endinterface

//--- hdl/sdreq_sync.sv
/*
 * Request filter, a plain shift chain per request bit.
 * Requests come from the controllers' own clock domain.
 * sync_stages must be 1 or more; latency is sync_stages sdclock edges.
 */
module sdreq_sync
   import sd_pkg::*;
#(
   parameter int sync_stages = 2           // chain depth
) (
   input  logic        sdclock,            // card clock
   input  logic        rst_n_i,            // sync reset, active low
   input  sd_vec_t     req_raw_i,          // raw requests from controllers
   sd_port_if.sync_mp  port                // filtered requests out
);

   //********************
   // shift chain
   //********************
   sd_vec_t stage_q [sync_stages];         // stage 0 samples the raw level

   always_ff @(posedge sdclock) begin
      if (!rst_n_i) begin
         stage_q <= '{default: '0};        // nobody requests after reset
      end else begin
         stage_q[0] <= req_raw_i;          // first sample
         for (int i = 1; i < sync_stages; i++) begin
            stage_q[i] <= stage_q[i-1];    // shift along
         end
      end
   end

   // last stage is the filtered level
   assign port.req = stage_q[sync_stages-1];

endmodule

//--- sd_arbiter/sd_card_switch.sv
/*
 * SD card access switch for six disk controllers (RK, DW, DM, DB, DX, MY).
 * Requests are levels; a controller owns the card while its ack is high.
 * Idle to ack is sync_stages + 1 edges; MISO goes to the controllers outside this block.
 */
module sd_card_switch
   import sd_pkg::*;
#(
   parameter int sync_stages = sync_stages_dflt  // request filter depth
) (
   input  logic    sdclock,                // card clock
   input  logic    rst_n_i,                // sync reset, active low
   input  sd_vec_t sd_req_i,               // raw requests
   input  sd_vec_t ctrl_cs_i,              // controllers' chip selects
   input  sd_vec_t ctrl_mosi_i,            // controllers' mosi
   input  sd_vec_t ctrl_sclk_i,            // controllers' sclk
   output sd_vec_t sd_ack_o,               // card grants
   output sd_vec_t disk_led_o,             // activity leds, active low
   output logic    sdcard_cs_o,            // to card
   output logic    sdcard_mosi_o,          // to card
   output logic    sdcard_sclk_o           // to card
);

   sd_port_if port_if ();                  // internal bundle

   // controller lines into the bundle
   assign port_if.cs   = ctrl_cs_i;
   assign port_if.mosi = ctrl_mosi_i;
   assign port_if.sclk = ctrl_sclk_i;

   //********************
   // request filter
   //********************
   sdreq_sync #(
      .sync_stages (sync_stages)
   ) sdreq_sync_i (
      .sdclock     (sdclock),
      .rst_n_i     (rst_n_i),
      .req_raw_i   (sd_req_i),
      .port        (port_if.sync_mp)
   );

   //********************
   // grant register
   //********************
   sd_grant_ctrl sd_grant_ctrl_i (
      .sdclock     (sdclock),
      .rst_n_i     (rst_n_i),
      .port        (port_if.arb_mp)
   );

   //********************
   // card line mux
   //********************
   sd_spi_mux sd_spi_mux_i (
      .port          (port_if.mux_mp),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o)
   );

   //********************
   // acks and leds
   //********************
   assign sd_ack_o   = port_if.grant.vec;  // grant straight out
   assign disk_led_o = ~sd_req_i;          // led lit while raw request is high

endmodule

//--- sd_arbiter/sd_grant_ctrl.sv
/*
 * Fixed-priority card grant, RK first and MY last.
 * A grant is never pre-empted; it is held until the owner's filtered request drops.
 * After a release the card stays idle for one cycle before the next grant.
 */
module sd_grant_ctrl
   import sd_pkg::*;
(
   input  logic        sdclock,            // card clock
   input  logic        rst_n_i,            // sync reset, active low
   sd_port_if.arb_mp   port                // filtered requests in, grant out
);

   sd_grant_u req_u;                       // requests seen by name
   sd_grant_u grant_q;                     // grant register
   sd_grant_u grant_d;                     // next grant
   logic      busy;                        // some controller owns the card

   assign req_u.vec = port.req;
   assign busy      = |grant_q.vec;

   //********************
   // next grant
   //********************
   always_comb begin
      grant_d = grant_q;                   // hold by default
      if (!busy) begin
         // idle, pick the highest pending request
         if (req_u.dev.rk) begin
            grant_d.dev.rk = 1'b1;
         end else if (req_u.dev.dw) begin
            grant_d.dev.dw = 1'b1;
         end else if (req_u.dev.dm) begin
            grant_d.dev.dm = 1'b1;
         end else if (req_u.dev.db) begin
            grant_d.dev.db = 1'b1;
         end else if (req_u.dev.dx) begin
            grant_d.dev.dx = 1'b1;
         end else if (req_u.dev.my) begin
            grant_d.dev.my = 1'b1;
         end
      end else begin
         // owner keeps the card until its own request drops
         // other requests just wait
         if (grant_q.dev.rk && !req_u.dev.rk) begin
            grant_d.dev.rk = 1'b0;
         end
         if (grant_q.dev.dw && !req_u.dev.dw) begin
            grant_d.dev.dw = 1'b0;
         end
         if (grant_q.dev.dm && !req_u.dev.dm) begin
            grant_d.dev.dm = 1'b0;
         end
         if (grant_q.dev.db && !req_u.dev.db) begin
            grant_d.dev.db = 1'b0;
         end
         if (grant_q.dev.dx && !req_u.dev.dx) begin
            grant_d.dev.dx = 1'b0;
         end
         if (grant_q.dev.my && !req_u.dev.my) begin
            grant_d.dev.my = 1'b0;
         end
      end
   end

   //********************
   // grant register
   //********************
   always_ff @(posedge sdclock) begin
      if (!rst_n_i) begin
         grant_q.vec <= '0;                // card free after reset
      end else begin
         grant_q <= grant_d;
      end
   end

   assign port.grant = grant_q;

endmodule

//--- sd_arbiter/sd_spi_mux.sv
/*
 * Card line mux, purely combinational.
 * Routes the owner's cs, mosi and sclk to the card; idle levels when nobody owns it.
 * Relies on the grant being one-hot or zero.
 */
module sd_spi_mux
   import sd_pkg::*;
(
   sd_port_if.mux_mp   port,               // grant and controller lines
   output logic        sdcard_cs_o,        // card chip select
   output logic        sdcard_mosi_o,      // card data in
   output logic        sdcard_sclk_o       // card clock
);

   sd_vec_t sel;                           // column select from the grant

   assign sel = port.grant.vec;

   //********************
   // line select
   //********************
   always_comb begin
      // nobody on the card, park the lines
      sdcard_cs_o   = idle_cs;
      sdcard_mosi_o = idle_mosi;
      sdcard_sclk_o = idle_sclk;
      for (int i = idx_rk; i <= idx_my; i++) begin
         if (sel[i]) begin
            sdcard_cs_o   = port.cs[i];    // owner's chip select
            sdcard_mosi_o = port.mosi[i];  // owner's data
            sdcard_sclk_o = port.sclk[i];  // owner's clock
         end
      end
   end

endmodule

//--- verification/sd_card_switch_chk.sv
/*
 * Concurrent checks on the card switch, bound to the top level.
 * The hold check assumes a filter depth of 2.
 */
module sd_card_switch_chk
   import sd_pkg::*;
(
   input logic    sdclock,                 // card clock
   input logic    rst_n_i,                 // sync reset, active low
   input sd_vec_t req_i,                   // raw requests
   input sd_vec_t ack_i                    // grants
);

   //********************
   // grant shape
   //********************
   a_onehot: assert property (@(posedge sdclock) disable iff (!rst_n_i)
      $onehot0(ack_i))
      else $error("more than one grant high: %b", ack_i);

   // cleared by the reset edge
   a_reset_clear: assert property (@(posedge sdclock)
      !rst_n_i |=> (ack_i == '0))
      else $error("grant not clear after a reset edge: %b", ack_i);

   //********************
   // no early release
   //********************
   for (genvar i = idx_rk; i <= idx_my; i++) begin : g_hold
      a_hold: assert property (@(posedge sdclock) disable iff (!rst_n_i)
         ($past(req_i[i], 1) && $past(req_i[i], 2) && $past(req_i[i], 3))
         |-> !$fell(ack_i[i]))
         else $error("grant %0d dropped while its request was still high", i);
   end

endmodule

bind sd_card_switch sd_card_switch_chk sd_card_switch_chk_i (
   .sdclock (sdclock),
   .rst_n_i (rst_n_i),
   .req_i   (sd_req_i),
   .ack_i   (sd_ack_o)
);

//--- verification/tb_sd_card_switch.sv
/*
 * Testbench for the SD card switch at the default filter depth of 2.
 * Inputs change on the falling edge. Outputs are compared 1 unit after each rising edge
 * against a cycle model of the filter and grant register.
 */
module tb_sd_card_switch
   import sd_pkg::*;
();

   localparam int n_tests       = 6;       // tests in the run
   localparam int stages        = sync_stages_dflt;
   localparam int clk_period    = 40;
   localparam int watchdog_time = n_tests * 200 * clk_period;

   logic      sdclock;
   logic      rst_n_i;
   sd_vec_t   sd_req_i;
   sd_vec_t   ctrl_cs_i;
   sd_vec_t   ctrl_mosi_i;
   sd_vec_t   ctrl_sclk_i;
   sd_vec_t   sd_ack_o;
   sd_vec_t   disk_led_o;
   logic      sdcard_cs_o;
   logic      sdcard_mosi_o;
   logic      sdcard_sclk_o;

   integer    seed;                        // $random state
   int        errors;                      // whole run
   int        test_errors;                 // current test only
   string     cur_test;
   sd_vec_t   m_sync [stages];             // model of the filter chain
   sd_grant_u m_grant;                     // model of the grant register
   sd_grant_u exp_grant;
   sd_grant_u got_grant;
   sd_grant_u exp_led;
   sd_grant_u got_led;
   logic [2:0] exp_lines;                  // cs, mosi, sclk
   sd_grant_u g_tmp;

   sd_card_switch #(
      .sync_stages   (stages)
   ) sd_card_switch_i (
      .sdclock       (sdclock),
      .rst_n_i       (rst_n_i),
      .sd_req_i      (sd_req_i),
      .ctrl_cs_i     (ctrl_cs_i),
      .ctrl_mosi_i   (ctrl_mosi_i),
      .ctrl_sclk_i   (ctrl_sclk_i),
      .sd_ack_o      (sd_ack_o),
      .disk_led_o    (disk_led_o),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o)
   );

   initial begin
      sdclock = 1'b0;
      forever #(clk_period / 2) sdclock = ~sdclock;
   end

   //********************
   // reference model
   //********************
   // one sdclock edge of filter and grant, returns the grant after the edge
   function automatic sd_grant_u ref_grant(input sd_vec_t raw, input logic rst_n);
      sd_vec_t   filt;
      sd_grant_u nxt;
      logic      found;
      filt  = m_sync[stages-1];            // level the grant logic sees now
      nxt   = m_grant;
      found = 1'b0;
      if (!rst_n) begin
         for (int i = 0; i < stages; i++) m_sync[i] = '0;
         nxt.vec = '0;
      end else begin
         if (m_grant.vec == '0) begin
            for (int i = idx_rk; i <= idx_my; i++) begin
               if (filt[i] && !found) begin
                  nxt.vec[i] = 1'b1;       // lowest index wins
                  found = 1'b1;
               end
            end
         end else if ((m_grant.vec & filt) == '0) begin
            nxt.vec = '0;                  // owner let go
         end
         for (int i = stages - 1; i > 0; i--) m_sync[i] = m_sync[i-1];
         m_sync[0] = raw;
      end
      m_grant = nxt;
      return nxt;
   endfunction

   // card lines expected for a grant, idle when nobody owns the card
   function automatic logic [2:0] ref_lines(input sd_grant_u g, input sd_vec_t cs,
                                            input sd_vec_t mosi, input sd_vec_t sclk);
      logic [2:0] lines;
      lines = {idle_cs, idle_mosi, idle_sclk};
      for (int i = idx_rk; i <= idx_my; i++) begin
         if (g.vec[i]) lines = {cs[i], mosi[i], sclk[i]};
      end
      return lines;
   endfunction

   function automatic sd_grant_u owner(input int idx);
      sd_grant_u g;
      g.vec = '0;
      g.vec[idx] = 1'b1;
      return g;
   endfunction

   //********************
   // compare tasks
   //********************
   task automatic check_grant(input string what, input sd_grant_u exp, input sd_grant_u got);
      if (got.vec !== exp.vec) begin
         $display("mismatch test %s %s: expected %b, actual %b",
                  cur_test, what, exp.vec, got.vec);
         errors++;
         test_errors++;
      end
   endtask

   task automatic check_line(input string what, input logic exp, input logic got);
      if (got !== exp) begin
         $display("mismatch test %s %s: expected %b, actual %b", cur_test, what, exp, got);
         errors++;
         test_errors++;
      end
   endtask

   // every edge, model first, then look at the settled outputs
   always @(posedge sdclock) begin
      exp_grant = ref_grant(sd_req_i, rst_n_i);
      #1;
      got_grant.vec = sd_ack_o;
      check_grant("ack", exp_grant, got_grant);
      exp_led.vec = ~sd_req_i;             // leds are active low
      got_led.vec = disk_led_o;
      check_grant("led", exp_led, got_led);
      exp_lines = ref_lines(exp_grant, ctrl_cs_i, ctrl_mosi_i, ctrl_sclk_i);
      check_line("cs", exp_lines[2], sdcard_cs_o);
      check_line("mosi", exp_lines[1], sdcard_mosi_o);
      check_line("sclk", exp_lines[0], sdcard_sclk_o);
   end

   //********************
   // stimulus helpers
   //********************
   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      $display("test %s finished with %0d errors", cur_test, test_errors);
   endtask

   task automatic drive_req(input sd_vec_t r);
      @(negedge sdclock);
      sd_req_i = r;
   endtask

   // wait for an ack pattern, give up after max_cycles edges
   task automatic wait_ack(input sd_grant_u want, input int max_cycles);
      int n;
      n = 0;
      do begin
         @(posedge sdclock);
         #1;
         n++;
      end while (sd_ack_o !== want.vec && n < max_cycles);
      if (sd_ack_o !== want.vec) begin
         $display("test %s: ack %b did not show up within %0d cycles",
                  cur_test, want.vec, max_cycles);
         errors++;
         test_errors++;
      end
   endtask

   task automatic expect_ack_after(input int edges, input sd_grant_u want);
      sd_grant_u got;
      repeat (edges) @(posedge sdclock);
      #1;
      got.vec = sd_ack_o;
      check_grant("ack", want, got);
   endtask

   task automatic randomize_lines();
      @(negedge sdclock);
      ctrl_cs_i   = sd_vec_t'($random(seed));
      ctrl_mosi_i = sd_vec_t'($random(seed));
      ctrl_sclk_i = sd_vec_t'($random(seed));
   endtask

   //********************
   // tests
   //********************
   initial begin
      seed        = 53;
      errors      = 0;
      m_grant.vec = '0;
      for (int i = 0; i < stages; i++) m_sync[i] = '0;
      rst_n_i     = 1'b0;
      sd_req_i    = '0;
      ctrl_cs_i   = '0;
      ctrl_mosi_i = '0;
      ctrl_sclk_i = '0;

      start_test("reset");
      repeat (2) @(posedge sdclock);       // two edges in reset
      @(negedge sdclock);
      rst_n_i = 1'b1;
      expect_ack_after(1, '0);
      check_line("cs", idle_cs, sdcard_cs_o);
      check_line("mosi", idle_mosi, sdcard_mosi_o);
      check_line("sclk", idle_sclk, sdcard_sclk_o);
      end_test();

      start_test("single_dw");
      g_tmp = owner(idx_dw);
      drive_req(g_tmp.vec);
      expect_ack_after(2, '0);             // still in the filter
      expect_ack_after(1, g_tmp);          // third edge
      repeat (4) @(negedge sdclock);
      drive_req('0);
      expect_ack_after(2, g_tmp);
      expect_ack_after(1, '0);
      end_test();

      start_test("priority");
      drive_req(owner(idx_my) | owner(idx_db) | owner(idx_rk));
      wait_ack(owner(idx_rk), 20);
      repeat (3) @(negedge sdclock);
      drive_req(owner(idx_my) | owner(idx_db));
      wait_ack(owner(idx_db), 20);
      repeat (3) @(negedge sdclock);
      drive_req(owner(idx_my));
      wait_ack(owner(idx_my), 20);
      drive_req('0);
      wait_ack('0, 20);
      end_test();

      start_test("no_preempt");
      g_tmp         = '0;
      g_tmp.dev.dx  = 1'b1;                // dx owns the card
      drive_req(g_tmp.vec);
      wait_ack(g_tmp, 20);
      drive_req(g_tmp.vec | owner(idx_rk));
      expect_ack_after(10, g_tmp);         // rk must wait
      drive_req(owner(idx_rk));
      wait_ack(owner(idx_rk), 20);
      drive_req('0);
      wait_ack('0, 20);
      end_test();

      start_test("routing");
      for (int i = idx_rk; i <= idx_my; i++) begin
         g_tmp = owner(i);
         drive_req(g_tmp.vec);
         wait_ack(g_tmp, 20);
         repeat (8) randomize_lines();     // lines checked each edge
         drive_req('0);
         wait_ack('0, 20);
      end
      end_test();

      start_test("leds");
      @(negedge sdclock);
      rst_n_i = 1'b0;
      for (int i = 0; i < 4; i++) begin
         drive_req(sd_vec_t'($random(seed)));
         #1;
         exp_led.vec = ~sd_req_i;
         got_led.vec = disk_led_o;
         check_grant("led", exp_led, got_led);
      end
      drive_req('0);
      repeat (2) @(negedge sdclock);       // flush the filter
      rst_n_i = 1'b1;
      wait_ack('0, 10);
      end_test();

      $display("tests run: %0d, errors: %0d", n_tests, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // run limit from the test count
   initial begin
      #(watchdog_time);
      $display("timeout: tests still running after %0d time units", watchdog_time);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule
